// ==== run.sh ====
#!/bin/sh
# Build and run the dcache testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f verilog.f --top-module dcache_tb \
	-Mdir obj_dir -o dcache_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/dcache_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -qx ">>> PASS" sim.log; then
	exit 0
fi
exit 1

// ==== source/dcache.sv ====
`timescale 1ns/1ps
`default_nettype none

module dcache (
	input  logic                 CLK,
	input  logic                 nRST,
	input  dcache_pkg::cpu_req_t cpu_req,
	output dcache_pkg::cpu_rsp_t cpu_rsp,
	output dcache_pkg::mem_req_t mem_req,
	input  dcache_pkg::mem_rsp_t mem_rsp
);

	dcache_pkg::store_cmd_t  cmd;
	dcache_pkg::store_stat_t stat;
	logic                    in_idle;

	// Arrays, lookup and memory address select
	dcache_store u_store (
		.CLK       (CLK),
		.nRST      (nRST),
		.cpu_req   (cpu_req),
		.in_idle   (in_idle),
		.cmd       (cmd),
		.mem_load  (mem_rsp.load),
		.stat      (stat),
		.load      (cpu_rsp.load),
		.mem_addr  (mem_req.addr),
		.mem_store (mem_req.store)
	);

	// Miss, fill and flush sequencing
	dcache_ctrl u_ctrl (
		.CLK       (CLK),
		.nRST      (nRST),
		.halt      (cpu_req.halt),
		.req_valid (cpu_req.ren | cpu_req.wen),
		.stat      (stat),
		.dwait     (mem_rsp.dwait),
		.cmd       (cmd),
		.in_idle   (in_idle),
		.mem_ren   (mem_req.ren),
		.mem_wen   (mem_req.wen),
		.flushed   (cpu_rsp.flushed)
	);

	assign cpu_rsp.hit = stat.hit;

endmodule

`default_nettype wire

// ==== source/dcache_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module dcache_ctrl (
	input  logic                    CLK,
	input  logic                    nRST,
	input  logic                    halt,
	input  logic                    req_valid,
	input  dcache_pkg::store_stat_t stat,
	input  logic                    dwait,
	output dcache_pkg::store_cmd_t  cmd,
	output logic                    in_idle,
	output logic                    mem_ren,
	output logic                    mem_wen,
	output logic                    flushed
);

	dcache_pkg::ctrl_state_e state;
	dcache_pkg::ctrl_state_e next_state;

	////////////////////////////////////////
	// State register
	////////////////////////////////////////

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			state <= dcache_pkg::IDLE;
		end else begin
			state <= next_state;
		end
	end

	////////////////////////////////////////
	// Next state and outputs
	////////////////////////////////////////

	always_comb begin
		next_state   = state;
		cmd.op       = dcache_pkg::NONE;
		cmd.addr_src = dcache_pkg::REQUEST;
		cmd.word_sel = 1'b0;
		mem_ren      = 1'b0;
		mem_wen      = 1'b0;
		flushed      = 1'b0;
		case (state)
			dcache_pkg::IDLE: begin
				// Halt wins over a pending access
				if (halt) begin
					next_state = dcache_pkg::FLUSH_CHK;
				end else if (req_valid && !stat.hit) begin
					next_state = stat.victim_dirty ? dcache_pkg::WB1 : dcache_pkg::FD1;
				end
			end
			// Victim write back, word 0 then word 1
			dcache_pkg::WB1: begin
				mem_wen      = 1'b1;
				cmd.addr_src = dcache_pkg::VICTIM;
				if (!dwait) begin
					next_state = dcache_pkg::WB2;
				end
			end
			dcache_pkg::WB2: begin
				mem_wen      = 1'b1;
				cmd.addr_src = dcache_pkg::VICTIM;
				cmd.word_sel = 1'b1;
				if (!dwait) begin
					next_state = dcache_pkg::FD1;
				end
			end
			// Fill from the request address into the LRU way
			dcache_pkg::FD1: begin
				mem_ren = 1'b1;
				if (!dwait) begin
					cmd.op     = dcache_pkg::FILL0;
					next_state = dcache_pkg::FD2;
				end
			end
			dcache_pkg::FD2: begin
				mem_ren      = 1'b1;
				cmd.word_sel = 1'b1;
				// Back to IDLE where the access now hits
				if (!dwait) begin
					cmd.op     = dcache_pkg::FILL1;
					next_state = dcache_pkg::IDLE;
				end
			end
			dcache_pkg::FLUSH_CHK: begin
				next_state = stat.any_dirty ? dcache_pkg::FLUSH_WB1 : dcache_pkg::FLUSHED;
			end
			// Lowest dirty line goes out
			dcache_pkg::FLUSH_WB1: begin
				mem_wen      = 1'b1;
				cmd.addr_src = dcache_pkg::DIRTY;
				if (!dwait) begin
					next_state = dcache_pkg::FLUSH_WB2;
				end
			end
			dcache_pkg::FLUSH_WB2: begin
				mem_wen      = 1'b1;
				cmd.addr_src = dcache_pkg::DIRTY;
				cmd.word_sel = 1'b1;
				// Clearing dirty moves the scan to the next line
				if (!dwait) begin
					cmd.op     = dcache_pkg::CLEAN;
					next_state = dcache_pkg::FLUSH_CHK;
				end
			end
			// Terminal until reset
			dcache_pkg::FLUSHED: flushed = 1'b1;
			default: next_state = dcache_pkg::IDLE;
		endcase
	end

	assign in_idle = (state == dcache_pkg::IDLE);

endmodule

`default_nettype wire

// ==== source/dcache_pkg.sv ====
`default_nettype none

package dcache_pkg;

	////////////////////////////////////////
	// Cache geometry
	////////////////////////////////////////

	localparam int ADDR_W        = 32;
	localparam int TAG_W         = 26;
	localparam int IDX_W         = 3;
	localparam int NUM_SETS      = 8;
	localparam int WORDS_PER_BLK = 2;
	// Whatever is left below tag, index and block offset
	localparam int BYTE_W        = ADDR_W - TAG_W - IDX_W - 1;

	typedef logic [31:0] word_t;

	// Address split, tag on top and byte offset at the bottom
	typedef struct packed {
		logic [TAG_W-1:0]  tag;
		logic [IDX_W-1:0]  idx;
		logic              blkoff;
		logic [BYTE_W-1:0] byteoff;
	} dcache_addr_t;

	// Same address word seen raw or as fields
	typedef union packed {
		word_t        raw;
		dcache_addr_t f;
	} dcache_addr_u;

	////////////////////////////////////////
	// Core and memory ports
	////////////////////////////////////////

	typedef struct packed {
		logic  halt;
		logic  ren;
		logic  wen;
		word_t addr;
		word_t store;
	} cpu_req_t;

	typedef struct packed {
		logic  hit;
		word_t load;
		logic  flushed;
	} cpu_rsp_t;

	typedef struct packed {
		logic  ren;
		logic  wen;
		word_t addr;
		word_t store;
	} mem_req_t;

	// Load is valid in the cycle where dwait is low
	typedef struct packed {
		logic  dwait;
		word_t load;
	} mem_rsp_t;

	////////////////////////////////////////
	// Controller to store
	////////////////////////////////////////

	typedef enum logic [3:0] {
		IDLE, WB1, WB2, FD1, FD2, FLUSH_CHK, FLUSH_WB1, FLUSH_WB2, FLUSHED
	} ctrl_state_e;

	// Array update requested for the next edge
	typedef enum logic [1:0] {NONE, FILL0, FILL1, CLEAN} store_op_e;

	// Which line forms the memory address
	typedef enum logic [1:0] {REQUEST, VICTIM, DIRTY} addr_src_e;

	typedef struct packed {
		store_op_e op;
		addr_src_e addr_src;
		logic      word_sel;
	} store_cmd_t;

	typedef struct packed {
		logic hit;
		logic victim_dirty;
		logic any_dirty;
	} store_stat_t;

endpackage

`default_nettype wire

// ==== source/dcache_store.sv ====
`timescale 1ns/1ps
`default_nettype none

module dcache_store (
	input  logic                    CLK,
	input  logic                    nRST,
	input  dcache_pkg::cpu_req_t    cpu_req,
	input  logic                    in_idle,
	input  dcache_pkg::store_cmd_t  cmd,
	input  dcache_pkg::word_t       mem_load,
	output dcache_pkg::store_stat_t stat,
	output dcache_pkg::word_t       load,
	output dcache_pkg::word_t       mem_addr,
	output dcache_pkg::word_t       mem_store
);

	// Payload arrays, indexed set then way then word
	logic [dcache_pkg::TAG_W-1:0] tags [dcache_pkg::NUM_SETS][2];
	dcache_pkg::word_t data [dcache_pkg::NUM_SETS][2][dcache_pkg::WORDS_PER_BLK];

	// Line state, one bit per way
	logic [dcache_pkg::NUM_SETS-1:0][1:0] valid;
	logic [dcache_pkg::NUM_SETS-1:0][1:0] dirty;
	// Way to replace next in each set
	logic [dcache_pkg::NUM_SETS-1:0]      lru;

	dcache_pkg::dcache_addr_u     req;
	dcache_pkg::dcache_addr_u     out_addr;
	logic [dcache_pkg::IDX_W-1:0] idx;
	logic [1:0]                   match;
	logic                         hit;
	logic                         hit_way;
	logic                         fill_way;

	// Flush scan result
	logic [dcache_pkg::IDX_W-1:0] dirty_idx;
	logic                         dirty_way;

	// Memory side line select
	logic [dcache_pkg::IDX_W-1:0] sel_idx;
	logic                         sel_way;
	logic [dcache_pkg::TAG_W-1:0] sel_tag;

	assign req.raw = cpu_req.addr;
	assign idx     = req.f.idx;

	////////////////////////////////////////
	// Lookup
	////////////////////////////////////////

	assign match[0] = valid[idx][0] && (tags[idx][0] == req.f.tag);
	assign match[1] = valid[idx][1] && (tags[idx][1] == req.f.tag);

	// Only one way can match a tag
	assign hit_way  = match[1];
	assign hit      = in_idle && (cpu_req.ren || cpu_req.wen) && (|match);
	assign fill_way = lru[idx];

	// Read word goes out even on a miss, hit qualifies it
	assign load = data[idx][hit_way][req.f.blkoff];

	assign stat.hit          = hit;
	assign stat.victim_dirty = valid[idx][fill_way] && dirty[idx][fill_way];
	assign stat.any_dirty    = |dirty;

	////////////////////////////////////////
	// Dirty scan
	////////////////////////////////////////

	// Walk down so the lowest set and way wins
	always_comb begin
		dirty_idx = '0;
		dirty_way = 1'b0;
		for (int s = dcache_pkg::NUM_SETS - 1; s >= 0; s--) begin
			for (int w = 1; w >= 0; w--) begin
				if (dirty[s][w]) begin
					dirty_idx = dcache_pkg::IDX_W'(s);
					dirty_way = w[0];
				end
			end
		end
	end

	////////////////////////////////////////
	// Memory address and store word
	////////////////////////////////////////

	always_comb begin
		sel_idx = idx;
		sel_way = fill_way;
		sel_tag = req.f.tag;
		case (cmd.addr_src)
			dcache_pkg::VICTIM: sel_tag = tags[idx][fill_way];
			dcache_pkg::DIRTY: begin
				sel_idx = dirty_idx;
				sel_way = dirty_way;
				sel_tag = tags[dirty_idx][dirty_way];
			end
			default: sel_tag = req.f.tag;
		endcase
		out_addr.f.tag     = sel_tag;
		out_addr.f.idx     = sel_idx;
		out_addr.f.blkoff  = cmd.word_sel;
		out_addr.f.byteoff = '0;
	end

	assign mem_addr  = out_addr.raw;
	assign mem_store = data[sel_idx][sel_way][cmd.word_sel];

	////////////////////////////////////////
	// Line state update
	////////////////////////////////////////

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			valid <= '0;
			dirty <= '0;
			lru   <= '0;
		end else begin
			// Point LRU at the other way on any hit
			if (hit) begin
				lru[idx] <= ~hit_way;
				if (cpu_req.wen) begin
					dirty[idx][hit_way] <= 1'b1;
				end
			end
			case (cmd.op)
				// Half filled line is not valid yet
				dcache_pkg::FILL0: begin
					valid[idx][fill_way] <= 1'b0;
					dirty[idx][fill_way] <= 1'b0;
				end
				dcache_pkg::FILL1: begin
					valid[idx][fill_way] <= 1'b1;
					dirty[idx][fill_way] <= 1'b0;
				end
				dcache_pkg::CLEAN: dirty[dirty_idx][dirty_way] <= 1'b0;
				default: ;
			endcase
		end
	end

	////////////////////////////////////////
	// Tag and data update
	////////////////////////////////////////

	always_ff @(posedge CLK) begin
		if (hit && cpu_req.wen) begin
			data[idx][hit_way][req.f.blkoff] <= cpu_req.store;
		end
		if (cmd.op == dcache_pkg::FILL0) begin
			data[idx][fill_way][0] <= mem_load;
		end
		// Tag lands with the second word
		if (cmd.op == dcache_pkg::FILL1) begin
			data[idx][fill_way][1] <= mem_load;
			tags[idx][fill_way]    <= req.f.tag;
		end
	end

endmodule

`default_nettype wire

// ==== tests/dcache_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module dcache_tb;

	localparam int                MEM_LAT   = 2;
	localparam dcache_pkg::word_t INIT_XOR  = 32'hc3a5_0f1e;
	localparam int                N_RAND    = 200;
	localparam logic [31:0]       SEED      = 32'hb78b;
	// Request and hit cycles around two write-back words and two fill words
	localparam int                MISS_MAX  = 4 * (MEM_LAT + 1) + 4;
	// Every line dirty with two words each plus the check state
	localparam int                FLUSH_MAX = 16 * (2 * (MEM_LAT + 1) + 1) + 4;
	localparam int                TIMEOUT   = 16 + (N_RAND + 16) * (MISS_MAX + 2)
		+ FLUSH_MAX + 64;

	logic                 CLK = 1'b0;
	logic                 nRST;
	dcache_pkg::cpu_req_t cpu_req;
	dcache_pkg::cpu_rsp_t cpu_rsp;
	dcache_pkg::mem_req_t mem_req;
	dcache_pkg::mem_rsp_t mem_rsp;

	// Expected memory image with the model's indexing
	dcache_pkg::word_t ref_mem [256];
	logic              hit_q;
	dcache_pkg::word_t load_q;
	int                rd_words = 0;
	int                cycles   = 0;
	int                errors;
	int                tests_failed;
	logic [31:0]       rng;
	// Write-back order watch
	logic              watch_on;
	logic [7:0]        watch_idx;
	dcache_pkg::word_t watch_data;

	dcache DUT (
		.CLK     (CLK),
		.nRST    (nRST),
		.cpu_req (cpu_req),
		.cpu_rsp (cpu_rsp),
		.mem_req (mem_req),
		.mem_rsp (mem_rsp)
	);

	mem_model #(.LAT(MEM_LAT), .INIT_XOR(INIT_XOR)) u_mem (
		.CLK  (CLK),
		.nRST (nRST),
		.req  (mem_req),
		.rsp  (mem_rsp)
	);

	always #5 CLK = ~CLK;

	////////////////////////////////////////
	// Edge monitor and run limit
	////////////////////////////////////////

	// Hit and load of the cycle that just ended
	always @(posedge CLK) begin
		hit_q  <= cpu_rsp.hit;
		load_q <= cpu_rsp.load;
		if (mem_req.ren && !mem_rsp.dwait) begin
			rd_words <= rd_words + 1;
		end
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT) begin
			$display("Run stopped after %0d cycles without finishing", cycles);
			$display(">>> FAIL");
			$finish;
		end
	end

	////////////////////////////////////////
	// Protocol checks
	////////////////////////////////////////

	assert property (@(posedge CLK) disable iff (!nRST)
		(cpu_rsp.hit && cpu_req.ren) |-> (cpu_rsp.load == ref_mem[cpu_req.addr[9:2]]))
		else report_mismatch("read hit returned a word other than the reference");

	assert property (@(posedge CLK) disable iff (!nRST)
		mem_req.wen |-> (mem_req.addr[1:0] == 2'b00))
		else report_mismatch("memory write to an address that is not word aligned");

	assert property (@(posedge CLK) disable iff (!nRST) !$fell(cpu_rsp.flushed))
		else report_mismatch("flushed fell before reset");

	// Victim word must be in memory before the fill is read
	assert property (@(posedge CLK) disable iff (!nRST)
		(watch_on && mem_req.ren && !mem_rsp.dwait) |-> (u_mem.mem[watch_idx] == watch_data))
		else report_mismatch("fill read came before the dirty word reached memory");

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic dcache_pkg::word_t make_addr(input int tag, input int idx,
		input logic blk);
		dcache_pkg::dcache_addr_u a;
		a.f.tag     = dcache_pkg::TAG_W'(tag);
		a.f.idx     = dcache_pkg::IDX_W'(idx);
		a.f.blkoff  = blk;
		a.f.byteoff = '0;
		return a.raw;
	endfunction

	task automatic report_mismatch(input string msg);
		errors++;
		$display("Mismatch at %0t: %s", $time, msg);
	endtask

	task automatic finish_test(input int num, input string name, input int errs_at_start);
		if (errors == errs_at_start) begin
			$display("Test %0d %s: ok", num, name);
		end else begin
			tests_failed++;
			$display("Test %0d %s: failed with %0d errors", num, name, errors - errs_at_start);
		end
	endtask

	// One core access held until a hit is seen at a rising edge
	task automatic access(input logic we, input dcache_pkg::word_t a,
		input dcache_pkg::word_t d, output dcache_pkg::word_t rd);
		int n;
		@(negedge CLK);
		cpu_req.ren   = !we;
		cpu_req.wen   = we;
		cpu_req.addr  = a;
		cpu_req.store = d;
		n = 0;
		do begin
			@(negedge CLK);
			n++;
		end while (!hit_q && n < MISS_MAX);
		cpu_req.ren = 1'b0;
		cpu_req.wen = 1'b0;
		rd = load_q;
		if (!hit_q) begin
			errors++;
			$display("Access to %h got no hit within %0d cycles", a, MISS_MAX);
		end else if (we) begin
			ref_mem[a[9:2]] = d;
		end
	endtask

	////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////

	initial begin
		dcache_pkg::word_t rd;
		dcache_pkg::word_t a;
		logic              we;
		int                base;
		int                n;
		cpu_req      = '0;
		nRST         = 1'b0;
		errors       = 0;
		tests_failed = 0;
		watch_on     = 1'b0;
		watch_idx    = '0;
		watch_data   = '0;
		rng          = SEED;
		for (int i = 0; i < 256; i++) begin
			ref_mem[8'(i)] = (dcache_pkg::word_t'(i) << 2) ^ INIT_XOR;
		end
		repeat (16) @(posedge CLK);
		@(negedge CLK);
		nRST = 1'b1;

		// Untouched address comes back with its start pattern
		base = errors;
		a = make_addr(1, 0, 1'b0);
		access(1'b0, a, '0, rd);
		assert (rd == (a ^ INIT_XOR)) else report_mismatch("read miss returned wrong word");
		finish_test(1, "read miss", base);

		base = errors;
		a = make_addr(2, 1, 1'b1);
		access(1'b1, a, 32'h1234_abcd, rd);
		access(1'b0, a, '0, rd);
		assert (rd == 32'h1234_abcd) else report_mismatch("read after write returned old word");
		a = make_addr(2, 1, 1'b0);
		access(1'b0, a, '0, rd);
		assert (rd == (a ^ INIT_XOR)) else report_mismatch("neighbour word changed by write");
		finish_test(2, "write then read", base);

		// A and B fill set 2 and C evicts B after A is touched again
		base = errors;
		access(1'b0, make_addr(4, 2, 1'b0), '0, rd);
		access(1'b0, make_addr(5, 2, 1'b0), '0, rd);
		access(1'b0, make_addr(4, 2, 1'b1), '0, rd);
		access(1'b0, make_addr(6, 2, 1'b0), '0, rd);
		n = rd_words;
		access(1'b0, make_addr(4, 2, 1'b0), '0, rd);
		assert (rd_words == n) else report_mismatch("recently used line was evicted");
		access(1'b0, make_addr(5, 2, 1'b0), '0, rd);
		assert (rd_words == n + 2) else report_mismatch("least recently used line stayed");
		finish_test(3, "LRU replacement", base);

		// Third tag in set 3 pushes the dirty line out
		base = errors;
		a = make_addr(7, 3, 1'b0);
		access(1'b1, a, 32'hdead_0007, rd);
		access(1'b0, make_addr(8, 3, 1'b0), '0, rd);
		watch_idx  = a[9:2];
		watch_data = 32'hdead_0007;
		watch_on   = 1'b1;
		access(1'b0, make_addr(9, 3, 1'b0), '0, rd);
		watch_on   = 1'b0;
		assert (u_mem.mem[a[9:2]] == 32'hdead_0007)
			else report_mismatch("dirty word not written back");
		finish_test(4, "dirty write-back", base);

		// Four tags over sets 4 to 7 at any byte offset
		base = errors;
		for (int i = 0; i < N_RAND; i++) begin
			rng = xorshift(rng);
			a   = make_addr(int'(rng[1:0]), 4 + int'(rng[3:2]), rng[4]);
			// Byte offset bits ride along on the core address
			a   = a | dcache_pkg::word_t'(rng[7:6]);
			we  = rng[5];
			rng = xorshift(rng);
			access(we, a, rng, rd);
		end
		finish_test(5, "random traffic", base);

		base = errors;
		@(negedge CLK);
		cpu_req.halt = 1'b1;
		n = 0;
		while (!cpu_rsp.flushed && n < FLUSH_MAX) begin
			@(negedge CLK);
			n++;
		end
		if (!cpu_rsp.flushed) begin
			errors++;
			$display("Cache did not report flushed within %0d cycles of halt", FLUSH_MAX);
		end
		repeat (4) @(negedge CLK);
		for (int i = 0; i < 256; i++) begin
			assert (u_mem.mem[8'(i)] == ref_mem[8'(i)])
				else report_mismatch($sformatf("memory word %0d differs after flush", i));
		end
		finish_test(6, "flush", base);

		$display("Tests run 6, failed %0d, errors %0d", tests_failed, errors);
		if (errors == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== tests/mem_model.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_model #(
	parameter int                LAT      = 2,
	parameter dcache_pkg::word_t INIT_XOR = 32'h0
) (
	input  logic                 CLK,
	input  logic                 nRST,
	input  dcache_pkg::mem_req_t req,
	output dcache_pkg::mem_rsp_t rsp
);

	// Word array over the low address range, indexed by word address
	dcache_pkg::word_t mem [256];
	logic [3:0]        cnt;
	logic              busy;

	assign busy      = req.ren || req.wen;
	// Wait is released for one cycle once the count reaches the latency
	assign rsp.dwait = !busy || (cnt != 4'(LAT));
	assign rsp.load  = mem[req.addr[9:2]];

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			cnt <= '0;
			// Start pattern built from the full byte address
			for (int i = 0; i < 256; i++) begin
				mem[8'(i)] <= (dcache_pkg::word_t'(i) << 2) ^ INIT_XOR;
			end
		end else if (busy && !rsp.dwait) begin
			// Transfer completes, next word waits again
			cnt <= '0;
			if (req.wen) begin
				mem[req.addr[9:2]] <= req.store;
			end
		end else if (busy) begin
			cnt <= cnt + 4'd1;
		end else begin
			cnt <= '0;
		end
	end

endmodule

`default_nettype wire

// ==== verilog.f ====
source/dcache_pkg.sv
source/dcache_store.sv
source/dcache_ctrl.sv
source/dcache.sv
tests/mem_model.sv
tests/dcache_tb.sv
